/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_bitmap_layer
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/bus_pkg.sv */
`include "render_consts.svh"

package bus_pkg;

    // Wishbone classic master request for reads only
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic [`ADDR_BITS-1:0] adr;   // Word address
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic [`WORD_BITS-1:0] dat;
        logic                  ack;
    } wb_rsp_t;

    // CPU side register port
    typedef struct packed {
        logic [`REG_ADDR_BITS-1:0] addr;
        logic [7:0]                wrdata;
        logic                      write;
    } reg_access_t;

endpackage

/* common/render_consts.svh */
`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Bus and line geometry
//////////////////////////////////////////////////////////////////////

`define WORD_BITS          32
`define ADDR_BITS          16
`define LB_IDX_BITS        10
`define LINE_IDX_BITS      9
`define LINE_PIXELS        640   // Fixed line length

//////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////

`define REG_ADDR_BITS      4
`define REG_CTRL           4'd0  // Enable and depth
`define REG_BASE_LO        4'd1
`define REG_BASE_HI        4'd2
`define REG_PALETTE        4'd3

// Reset values and defaults
`define BASE_RESET         16'h8000
`define FIFO_DEPTH_DEFAULT 4

`endif

/* common/render_pkg.sv */
`include "render_consts.svh"

package render_pkg;

    // Colour depth with code 3 reserved and treated as 8 bpp
    typedef enum logic [1:0] {
        DEPTH_2BPP = 2'd0,
        DEPTH_4BPP = 2'd1,
        DEPTH_8BPP = 2'd2
    } depth_t;

    // Layer configuration as seen by fetch and unpack
    typedef struct packed {
        logic                  enable;
        depth_t                depth;
        logic [`ADDR_BITS-1:0] base;
        logic [3:0]            pal_offset;
    } layer_cfg_t;

    // One bus word of pixel data
    // Byte view for 8 bpp and for the bit pairs of 2 bpp,
    // nibble view for 4 bpp
    typedef union packed {
        logic [3:0][7:0] bytes;     // bytes[0] is pixel data byte 0
        logic [7:0][3:0] nibbles;   // nibbles[1] is the high nibble of byte 0
    } pixel_word_t;

    // Line buffer write port
    typedef struct packed {
        logic                    wren;
        logic [`LB_IDX_BITS-1:0] idx;
        logic [7:0]              data;
    } lb_write_t;

endpackage

/* fetch/bitmap_fetch.sv */
`include "render_consts.svh"

module bitmap_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  render_pkg::layer_cfg_t       cfg,
    input  logic [`LINE_IDX_BITS-1:0]    line_idx,
    input  logic                         line_render_start,
    output bus_pkg::wb_req_t             wb_req,
    input  bus_pkg::wb_rsp_t             wb_rsp,
    input  logic                         full,
    output logic                         push,
    output render_pkg::pixel_word_t      push_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,    // cyc and stb high, waiting for ack
        ST_WAIT    // Gap cycle that also holds while the FIFO is full
    } state_t;

    state_t                state;
    logic [`ADDR_BITS-1:0] adr_r;
    logic [7:0]            word_cnt;
    logic [7:0]            words_per_line;
    logic [11:0]           line_mul5;
    logic [`ADDR_BITS-1:0] line_offset;
    logic [`ADDR_BITS-1:0] line_addr;
    logic                  last_word;
    logic                  next_req;

    //////////////////////////////////////////////////////////////////////
    // Line start address
    //////////////////////////////////////////////////////////////////////

    // 640 pixels is 5 * 2^n words, so the multiply is a shift and add
    assign line_mul5 = {3'b0, line_idx} + {1'b0, line_idx, 2'b0};

    always_comb begin
        case (cfg.depth)
            render_pkg::DEPTH_2BPP: begin
                words_per_line = 8'd40;
                line_offset    = `ADDR_BITS'({line_mul5, 3'b0});
            end
            render_pkg::DEPTH_4BPP: begin
                words_per_line = 8'd80;
                line_offset    = `ADDR_BITS'({line_mul5, 4'b0});
            end
            default: begin   // 8 bpp and the reserved code
                words_per_line = 8'd160;
                line_offset    = `ADDR_BITS'({line_mul5, 5'b0});   // Wraps mod 2^16
            end
        endcase
    end

    assign line_addr = cfg.base + line_offset;
    assign last_word = (word_cnt == words_per_line - 8'd1);
    assign next_req  = (state == ST_WAIT) && !full;

    //////////////////////////////////////////////////////////////////////
    // Wishbone master FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            word_cnt <= 8'd0;
        end else if (line_render_start) begin
            state    <= ST_REQ;   // FIFO is flushed on the same edge
            word_cnt <= 8'd0;
        end else begin
            case (state)
                ST_REQ: begin
                    if (wb_rsp.ack) begin
                        word_cnt <= word_cnt + 8'd1;
                        state    <= last_word ? ST_IDLE : ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (!full)
                        state <= ST_REQ;
                end
                default: ;
            endcase
        end
    end

    // Address advances as each new request is issued
    always_ff @(posedge clk) begin
        if (line_render_start)
            adr_r <= line_addr;
        else if (next_req)
            adr_r <= adr_r + `ADDR_BITS'(1);
    end

    assign wb_req = '{cyc: (state == ST_REQ), stb: (state == ST_REQ), adr: adr_r};

    // Word goes straight into the FIFO at the ack edge
    assign push      = (state == ST_REQ) && wb_rsp.ack;
    assign push_data = wb_rsp.dat;

endmodule

/* pixel/pixel_unpack.sv */
`include "render_consts.svh"

module pixel_unpack (
    input  logic                    clk,
    input  logic                    rst,
    input  render_pkg::layer_cfg_t  cfg,
    input  logic                    line_render_start,
    input  logic                    empty,
    output logic                    pop,
    input  render_pkg::pixel_word_t pop_data,
    output render_pkg::lb_write_t   linebuf,
    output logic                    line_render_done
);

    localparam logic [`LB_IDX_BITS-1:0] LAST_IDX = `LB_IDX_BITS'(`LINE_PIXELS - 1);

    logic                    active_r;   // Line in progress
    logic                    busy_r;     // word_r still has pixels left
    logic                    done_r;
    logic [3:0]              pix_r;
    logic [`LB_IDX_BITS-1:0] idx_r;
    render_pkg::pixel_word_t word_r;

    render_pkg::pixel_word_t src;
    logic [3:0]              pix;
    logic [3:0]              last_pix;
    logic [7:0]              cur_byte;
    logic [7:0]              raw;
    logic [7:0]              color;
    logic                    emit;

    logic                    wren_r;
    logic [`LB_IDX_BITS-1:0] wr_idx_r;
    logic [7:0]              wr_data_r;

    //////////////////////////////////////////////////////////////////////
    // Pixel select
    //////////////////////////////////////////////////////////////////////

    // Pixel 0 comes straight from the FIFO head in the pop cycle
    assign pop  = active_r && !busy_r && !empty;
    assign emit = busy_r || pop;
    assign src  = busy_r ? word_r : pop_data;
    assign pix  = busy_r ? pix_r : 4'd0;

    always_comb begin
        cur_byte = src.bytes[pix[3:2]];
        case (cfg.depth)
            render_pkg::DEPTH_2BPP: begin
                last_pix = 4'd15;
                raw      = {6'b0, cur_byte[{~pix[1:0], 1'b1} -: 2]};   // MSB pair first
            end
            render_pkg::DEPTH_4BPP: begin
                last_pix = 4'd7;
                raw      = {4'b0, src.nibbles[{pix[2:1], ~pix[0]}]};  // High nibble first
            end
            default: begin
                last_pix = 4'd3;
                raw      = src.bytes[pix[1:0]];
            end
        endcase
    end

    // Palette offset only lands on non-zero pixels below 16
    always_comb begin
        if (raw[7:4] == 4'd0 && raw != 8'd0)
            color = {cfg.pal_offset, raw[3:0]};
        else
            color = raw;
    end

    //////////////////////////////////////////////////////////////////////
    // Counters and control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_r <= 1'b0;
            busy_r   <= 1'b0;
            pix_r    <= 4'd0;
            idx_r    <= '0;
            wren_r   <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            wren_r <= emit;
            if (line_render_start) begin
                active_r <= 1'b1;
                busy_r   <= 1'b0;
                pix_r    <= 4'd0;
                idx_r    <= '0;
                done_r   <= 1'b0;
            end else begin
                if (emit) begin
                    busy_r <= (pix != last_pix);
                    pix_r  <= pix + 4'd1;
                    idx_r  <= idx_r + 1'b1;
                    if (idx_r == LAST_IDX)
                        active_r <= 1'b0;   // No more pops this line
                end
                if (wren_r && wr_idx_r == LAST_IDX)
                    done_r <= 1'b1;
            end
        end
    end

    // Word and write payload
    always_ff @(posedge clk) begin
        if (pop)
            word_r <= pop_data;
        if (emit) begin
            wr_idx_r  <= idx_r;
            wr_data_r <= color;
        end
    end

    assign linebuf          = '{wren: wren_r, idx: wr_idx_r, data: wr_data_r};
    assign line_render_done = done_r;

endmodule

/* rtl/bitmap_layer.sv */
`include "render_consts.svh"

module bitmap_layer (
    input  logic                      clk,
    input  logic                      rst,
    input  bus_pkg::reg_access_t      regs,
    output logic [7:0]                regs_rddata,
    input  logic [`LINE_IDX_BITS-1:0] line_idx,
    input  logic                      line_render_start,
    output logic                      line_render_done,
    output logic                      layer_enabled,
    output bus_pkg::wb_req_t          wb_req,
    input  bus_pkg::wb_rsp_t          wb_rsp,
    output render_pkg::lb_write_t     linebuf
);

    render_pkg::layer_cfg_t  cfg;
    render_pkg::pixel_word_t push_data;
    render_pkg::pixel_word_t pop_data;
    logic                    push;
    logic                    pop;
    logic                    full;
    logic                    empty;

    assign layer_enabled = cfg.enable;

    layer_regs i_layer_regs (
        .clk         (clk),
        .rst         (rst),
        .regs        (regs),
        .regs_rddata (regs_rddata),
        .cfg         (cfg)
    );

    bitmap_fetch i_bitmap_fetch (
        .clk               (clk),
        .rst               (rst),
        .cfg               (cfg),
        .line_idx          (line_idx),
        .line_render_start (line_render_start),
        .wb_req            (wb_req),
        .wb_rsp            (wb_rsp),
        .full              (full),
        .push              (push),
        .push_data         (push_data)
    );

    // Start of line also drops any stale words
    word_fifo #(
        .DEPTH (`FIFO_DEPTH_DEFAULT)
    ) i_word_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (line_render_start),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    pixel_unpack i_pixel_unpack (
        .clk               (clk),
        .rst               (rst),
        .cfg               (cfg),
        .line_render_start (line_render_start),
        .empty             (empty),
        .pop               (pop),
        .pop_data          (pop_data),
        .linebuf           (linebuf),
        .line_render_done  (line_render_done)
    );

endmodule

/* rtl/layer_regs.sv */
`include "render_consts.svh"

module layer_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  bus_pkg::reg_access_t   regs,
    output logic [7:0]             regs_rddata,
    output render_pkg::layer_cfg_t cfg
);

    //////////////////////////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.enable     <= 1'b0;
            cfg.depth      <= render_pkg::DEPTH_2BPP;
            cfg.base       <= `BASE_RESET;
            cfg.pal_offset <= 4'd0;
        end else if (regs.write) begin
            case (regs.addr)
                `REG_CTRL: begin
                    cfg.enable <= regs.wrdata[0];
                    cfg.depth  <= render_pkg::depth_t'(regs.wrdata[6:5]);
                end
                `REG_BASE_LO: cfg.base[7:0]    <= regs.wrdata;
                `REG_BASE_HI: cfg.base[15:8]   <= regs.wrdata;
                `REG_PALETTE: cfg.pal_offset   <= regs.wrdata[3:0];
                default: ;   // Writes to other addresses are dropped
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read-back
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (regs.addr)
            `REG_CTRL:    regs_rddata = {1'b0, cfg.depth, 4'b0, cfg.enable};
            `REG_BASE_LO: regs_rddata = cfg.base[7:0];
            `REG_BASE_HI: regs_rddata = cfg.base[15:8];
            `REG_PALETTE: regs_rddata = {4'b0, cfg.pal_offset};
            default:      regs_rddata = 8'h00;
        endcase
    end

endmodule

/* rtl/word_fifo.sv */
module word_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    push,
    input  render_pkg::pixel_word_t push_data,
    output logic                    full,
    input  logic                    pop,
    output render_pkg::pixel_word_t pop_data,
    output logic                    empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    render_pkg::pixel_word_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push && !flush)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];   // Head word
    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);

endmodule

/* src.f */
+incdir+common
common/bus_pkg.sv
common/render_pkg.sv
rtl/layer_regs.sv
fetch/bitmap_fetch.sv
rtl/word_fifo.sv
pixel/pixel_unpack.sv
rtl/bitmap_layer.sv
testbench/bitmap_layer_sva.sv
testbench/tb_bitmap_layer.sv

/* testbench/bitmap_layer_sva.sv */
`include "render_consts.svh"

module bitmap_layer_sva (
    input logic             clk,
    input logic             rst,
    input logic             line_render_start,
    input logic             line_render_done,
    input bus_pkg::wb_req_t wb_req,
    input bus_pkg::wb_rsp_t wb_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    logic started_r;        // A line has been started since reset
    int   fail_count = 0;   // Failed assertions so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            started_r <= 1'b0;
        else if (line_render_start)
            started_r <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////
    // Wishbone classic master
    ////////////////////////////////////////////////////////////////////

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb |-> wb_req.cyc)
        else begin
            $error("stb high without cyc");
            fail_count++;
        end

    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
        else begin
            $error("stb dropped or adr changed before ack");
            fail_count++;
        end

    // Line start only right after reset or once the previous line is done
    a_start_rule: assert property (@(posedge clk) disable iff (rst)
        line_render_start |-> (!started_r || line_render_done))
        else begin
            $error("line_render_start while a line is still rendering");
            fail_count++;
        end

endmodule

bind bitmap_layer bitmap_layer_sva i_bitmap_layer_sva (.*);

/* testbench/tb_bitmap_layer.sv */
`include "render_consts.svh"

module tb_bitmap_layer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * `LINE_PIXELS * 8 + 1000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic [1:0]                 depth;
        logic [`ADDR_BITS-1:0]      base;
        logic [3:0]                 pal;
        logic [`LINE_IDX_BITS-1:0]  line;
        logic                       zero_delay;   // Ack in the first cycle
        logic [7:0]                 words;        // Expected bus cycles
    } test_t;

    // Depth 3 is the reserved code and renders as 8 bpp
    test_t tests [NUM_TESTS] = '{
        '{2'd0, 16'h1000, 4'h5, 9'd3,   1'b0, 8'd40},
        '{2'd1, 16'hA000, 4'h3, 9'd100, 1'b0, 8'd80},
        '{2'd2, 16'h0040, 4'h7, 9'd479, 1'b0, 8'd160},
        '{2'd3, 16'h0200, 4'h9, 9'd2,   1'b0, 8'd160},
        '{2'd2, 16'hFF00, 4'h2, 9'd10,  1'b1, 8'd160},
        '{2'd2, 16'h0500, 4'hC, 9'd0,   1'b1, 8'd160}
    };

    logic                       clk = 1'b0;
    logic                       rst;
    bus_pkg::reg_access_t       regs;
    logic [7:0]                 regs_rddata;
    logic [`LINE_IDX_BITS-1:0]  line_idx;
    logic                       line_render_start;
    logic                       line_render_done;
    logic                       layer_enabled;
    bus_pkg::wb_req_t           wb_req;
    bus_pkg::wb_rsp_t           wb_rsp = '0;
    render_pkg::lb_write_t      linebuf;

    logic [31:0]                lfsr_state = 32'h4f8c;
    logic                       zero_delay = 1'b0;
    logic                       mem_busy = 1'b0;
    int                         wait_left = 0;
    logic                       collecting = 1'b0;
    int                         errors = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;

    logic [`ADDR_BITS-1:0]      adr_q[$];
    logic [`LB_IDX_BITS-1:0]    idx_q[$];
    logic [7:0]                 data_q[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    bitmap_layer i_bitmap_layer (
        .clk               (clk),
        .rst               (rst),
        .regs              (regs),
        .regs_rddata       (regs_rddata),
        .line_idx          (line_idx),
        .line_render_start (line_render_start),
        .line_render_done  (line_render_done),
        .layer_enabled     (layer_enabled),
        .wb_req            (wb_req),
        .wb_rsp            (wb_rsp),
        .linebuf           (linebuf)
    );

    ////////////////////////////////////////////////////////////////////
    // Memory model and helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Two bits with one LFSR step for each
    function automatic logic [1:0] draw_delay();
        logic [1:0] d;
        d[0] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        d[1] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        return d;
    endfunction

    function automatic logic [31:0] mem_word(logic [`ADDR_BITS-1:0] adr);
        return {adr, ~adr};
    endfunction

    // Byte 0 first, MSBs first inside a byte
    function automatic logic [7:0] expected_pixel(logic [1:0] depth, logic [31:0] w,
                                                  int p, logic [3:0] pal);
        logic [7:0] v;
        case (depth)
            2'd0:    v = {6'b0, w[8 * (p / 4) + 6 - 2 * (p % 4) +: 2]};
            2'd1:    v = {4'b0, w[8 * (p / 2) + ((p % 2 == 0) ? 4 : 0) +: 4]};
            default: v = w[8 * p +: 8];
        endcase
        if (v != 8'd0 && v[7:4] == 4'd0)
            v = v + {pal, 4'b0};
        return v;
    endfunction

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (rst) begin
            wb_rsp   = '0;
            mem_busy = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp = '0;   // Taken at this edge
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                wait_left = zero_delay ? 0 : int'(draw_delay());
            end
            if (wait_left == 0) begin
                wb_rsp.dat = mem_word(wb_req.adr);
                wb_rsp.ack = 1'b1;
                mem_busy   = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // Sampled mid cycle where everything is settled
    always @(negedge clk) begin
        if (collecting) begin
            if (linebuf.wren) begin
                idx_q.push_back(linebuf.idx);
                data_q.push_back(linebuf.data);
            end
            if (wb_req.stb && wb_rsp.ack)
                adr_q.push_back(wb_req.adr);
        end
    end

    task automatic write_reg(logic [3:0] addr, logic [7:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        regs = '{addr: addr, wrdata: data, write: 1'b1};
        @(posedge clk);
        #DRIVE_DELAY;
        regs.write = 1'b0;
    endtask

    task automatic check_reg(logic [3:0] addr, logic [7:0] exp);
        @(posedge clk);
        #DRIVE_DELAY;
        regs.addr  = addr;
        regs.write = 1'b0;
        @(negedge clk);
        assert (regs_rddata == exp) else begin
            $display("MISMATCH at %0t: register %0d reads %h, expected %h",
                     $time, addr, regs_rddata, exp);
            errors++;
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Register tests
    ////////////////////////////////////////////////////////////////////

    task automatic test_registers();
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        check_bit(line_render_done, 1'b0, "line_render_done after reset");
        check_bit(linebuf.wren, 1'b0, "linebuf.wren after reset");
        check_bit(wb_req.cyc, 1'b0, "wb_req.cyc after reset");
        check_bit(wb_req.stb, 1'b0, "wb_req.stb after reset");
        check_reg(`REG_CTRL, 8'h00);
        check_reg(`REG_BASE_LO, 8'(`BASE_RESET));
        check_reg(`REG_BASE_HI, 8'(`BASE_RESET >> 8));
        check_reg(`REG_PALETTE, 8'h00);
        check_reg(4'd7, 8'h00);
        write_reg(`REG_CTRL, 8'hFF);   // Only enable and depth are held
        check_reg(`REG_CTRL, 8'h61);
        check_bit(layer_enabled, 1'b1, "layer_enabled");
        write_reg(`REG_CTRL, 8'h40);
        check_reg(`REG_CTRL, 8'h40);
        check_bit(layer_enabled, 1'b0, "layer_enabled");
        write_reg(`REG_BASE_LO, 8'h5A);
        write_reg(`REG_BASE_HI, 8'hC3);
        write_reg(`REG_PALETTE, 8'hF7);
        write_reg(4'd9, 8'hAA);
        check_reg(`REG_BASE_LO, 8'h5A);
        check_reg(`REG_BASE_HI, 8'hC3);
        check_reg(`REG_PALETTE, 8'h07);
        check_reg(4'd9, 8'h00);
        finish_test("registers", errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Line tests
    ////////////////////////////////////////////////////////////////////

    task automatic run_line(int t);
        test_t                 tc;
        int                    errs_before;
        int                    ppw;
        int                    addr_full;
        logic [`ADDR_BITS-1:0] exp_adr;
        logic [7:0]            exp_pix;
        tc          = tests[t];
        errs_before = errors;
        write_reg(`REG_CTRL, {1'b0, tc.depth, 4'b0, 1'b1});
        write_reg(`REG_BASE_LO, tc.base[7:0]);
        write_reg(`REG_BASE_HI, tc.base[15:8]);
        write_reg(`REG_PALETTE, {4'b0, tc.pal});
        zero_delay = tc.zero_delay;
        adr_q.delete();
        idx_q.delete();
        data_q.delete();
        collecting = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        line_idx          = tc.line;
        line_render_start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        line_render_start = 1'b0;
        while (!line_render_done)
            @(negedge clk);
        repeat (3) @(negedge clk);   // Catch stray writes after done
        collecting = 1'b0;

        assert (adr_q.size() == int'(tc.words)) else begin
            $display("MISMATCH at %0t: %0d bus cycles, expected %0d",
                     $time, adr_q.size(), tc.words);
            errors++;
        end
        for (int n = 0; n < adr_q.size() && n < int'(tc.words); n++) begin
            addr_full = int'(tc.base) + int'(tc.line) * int'(tc.words) + n;
            exp_adr   = addr_full[15:0];
            assert (adr_q[n] == exp_adr) else begin
                $display("MISMATCH at %0t: bus cycle %0d adr %h, expected %h",
                         $time, n, adr_q[n], exp_adr);
                errors++;
            end
        end

        assert (idx_q.size() == `LINE_PIXELS) else begin
            $display("MISMATCH at %0t: %0d line buffer writes, expected %0d",
                     $time, idx_q.size(), `LINE_PIXELS);
            errors++;
        end
        ppw = `LINE_PIXELS / int'(tc.words);
        for (int i = 0; i < idx_q.size() && i < `LINE_PIXELS; i++) begin
            addr_full = int'(tc.base) + int'(tc.line) * int'(tc.words) + i / ppw;
            exp_pix   = expected_pixel(tc.depth, mem_word(addr_full[15:0]), i % ppw, tc.pal);
            assert (idx_q[i] == `LB_IDX_BITS'(i) && data_q[i] == exp_pix) else begin
                $display("MISMATCH at %0t: write %0d idx %0d data %h, expected idx %0d data %h",
                         $time, i, idx_q[i], data_q[i], i, exp_pix);
                errors++;
            end
        end
        finish_test($sformatf("line test %0d, depth %0d, line %0d", t, tc.depth, tc.line),
                    errs_before);
    endtask

    initial begin
        rst               = 1'b1;
        regs              = '0;
        line_idx          = '0;
        line_render_start = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        test_registers();
        for (int t = 0; t < NUM_TESTS; t++)
            run_line(t);
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors,
                 i_bitmap_layer.i_bitmap_layer_sva.fail_count);
        if (errors == 0 && i_bitmap_layer.i_bitmap_layer_sva.fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, line rendering never completed", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
